//--- rv_core.f
+incdir+src
src/rv_core_pkg.sv
src/fetch_pc.sv
src/decode_stage.sv
src/register_file.sv
src/execute_stage.sv
src/rv_core.sv
verification/rv_core_sva.sv
verification/rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  # rtl, pipeline order
  - include_dirs:
      - src
    files:
      - src/rv_core_pkg.sv
      - src/fetch_pc.sv
      - src/decode_stage.sv
      - src/register_file.sv
      - src/execute_stage.sv
      - src/rv_core.sv
  # assertions and testbench
  - target: simulation
    include_dirs:
      - src
    files:
      - verification/rv_core_sva.sv
      - verification/rv_core_tb.sv

//--- verification/rv_core_tb.sv
`include "rv_core_settings.svh"

module rv_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam rv_core_pkg::inst_t NOP = 32'h0000_0013;
  localparam rv_core_pkg::inst_t EBREAK = 32'h0010_0073;
  // instruction counts, also size the run limit
  localparam int N_ADDI = 32;
  localparam int N_CHAIN = 8;
  localparam int N_AUIPC = 8;
  localparam int N_POST = 6;
  localparam int CYCLE_LIMIT = 3 + 1 + N_ADDI + 2 * N_CHAIN + N_AUIPC + 1 + 6 + 1 + N_POST + 20;

  logic                 clk = 1'b0;
  logic                 reset;
  rv_core_pkg::inst_t   inst;
  rv_core_pkg::word_t   current_pc;
  rv_core_pkg::word_t   next_pc;
  rv_core_pkg::retire_t retire;
  logic                 halted;

  // reference model state
  rv_core_pkg::word_t   shadow [32];
  rv_core_pkg::word_t   model_pc;
  logic                 model_halted;
  logic                 exp_halted;
  // one entry per driven instruction, oldest first
  rv_core_pkg::retire_t exp_q [$];
  logic [31:0]          lfsr = 32'h3ac7;
  int                   errors = 0;
  int                   checks = 0;
  int                   cycle_count = 0;

  rv_core dut0 (
    .clk        (clk),
    .reset      (reset),
    .inst       (inst),
    .current_pc (current_pc),
    .next_pc    (next_pc),
    .retire     (retire),
    .halted     (halted)
  );

  always #50 clk = ~clk;

  // hang guard
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
      $display("Test FAILED");
      $finish;
    end
  end

  // galois lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // low width bits of v, sign extended to xlen
  function automatic rv_core_pkg::word_t sign_extend(input logic [31:0] v, input int width);
    rv_core_pkg::word_t w;
    w = rv_core_pkg::word_t'(v) << (`XLEN - width);
    return rv_core_pkg::word_t'($signed(w) >>> (`XLEN - width));
  endfunction

  function automatic rv_core_pkg::inst_t enc_addi(input rv_core_pkg::reg_id_t rd, rs1,
                                                  input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic rv_core_pkg::inst_t enc_add(input rv_core_pkg::reg_id_t rd, rs1, rs2);
    return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic rv_core_pkg::inst_t enc_auipc(input rv_core_pkg::reg_id_t rd,
                                                   input logic [19:0] imm);
    return {imm, rd, 7'b0010111};
  endfunction

  // isa level model, one call per fetched instruction
  function automatic rv_core_pkg::retire_t model_step(input rv_core_pkg::inst_t i);
    rv_core_pkg::retire_t r;
    logic                 writes;
    r = '0;
    writes = 1'b0;
    r.valid = !model_halted;
    r.pc = model_pc;
    r.rd = i[11:7];
    if (i[6:0] == 7'b0010011 && i[14:12] == 3'b000) begin
      r.data = shadow[i[19:15]] + sign_extend(32'(i[31:20]), 12);
      writes = 1'b1;
    end else if (i[6:0] == 7'b0110011 && i[14:12] == 3'b000 && i[31:25] == 7'b0) begin
      r.data = shadow[i[19:15]] + shadow[i[24:20]];
      writes = 1'b1;
    end else if (i[6:0] == 7'b0010111) begin
      r.data = model_pc + sign_extend({i[31:12], 12'b0}, 32);
      writes = 1'b1;
    end else if (i == EBREAK) begin
      r.ebreak = r.valid;
    end else begin
      r.illegal = r.valid;
    end
    // x0 stays zero in the shadow too
    r.wrote = r.valid && writes && (r.rd != '0);
    if (r.wrote) begin
      shadow[r.rd] = r.data;
    end
    // pc still advances on the ebreak itself
    if (!model_halted) begin
      model_pc = model_pc + 64'd4;
    end
    if (r.ebreak) begin
      model_halted = 1'b1;
    end
    return r;
  endfunction

  task automatic check_word(input rv_core_pkg::word_t got, exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_retire(input rv_core_pkg::retire_t got, exp);
    check_bit(got.valid, exp.valid, "retire.valid");
    // payload only matters for real retires
    if (exp.valid) begin
      check_word(got.pc, exp.pc, "retire.pc");
      check_word(rv_core_pkg::word_t'(got.rd), rv_core_pkg::word_t'(exp.rd), "retire.rd");
      check_bit(got.wrote, exp.wrote, "retire.wrote");
      check_bit(got.illegal, exp.illegal, "retire.illegal");
      check_bit(got.ebreak, exp.ebreak, "retire.ebreak");
      if (exp.wrote) begin
        check_word(got.data, exp.data, "retire.data");
      end
    end
  endtask

  // retire shows the instruction driven two edges back
  task automatic observe_retire();
    rv_core_pkg::retire_t exp;
    if (exp_q.size() > 2) begin
      exp = exp_q.pop_front();
      check_retire(retire, exp);
      if (exp.ebreak) begin
        exp_halted = 1'b1;
      end
    end else begin
      check_bit(retire.valid, 1'b0, "retire.valid before pipeline fill");
    end
    check_bit(halted, exp_halted, "halted");
  endtask

  // drive at the edge, check at the following low phase
  task automatic issue(input rv_core_pkg::inst_t i);
    rv_core_pkg::word_t fetch_pc_exp;
    @(posedge clk);
    inst <= i;
    fetch_pc_exp = model_pc;
    exp_q.push_back(model_step(i));
    @(negedge clk);
    check_word(current_pc, fetch_pc_exp, "current_pc");
    check_word(next_pc, model_pc, "next_pc");
    observe_retire();
  endtask

  task automatic test_reset();
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    // nop held through reset is the first fetch
    exp_q.push_back(model_step(inst));
    @(negedge clk);
    check_word(current_pc, `RESET_PC, "current_pc after reset");
    check_word(next_pc, `RESET_PC + 64'd4, "next_pc after reset");
    check_bit(retire.valid, 1'b0, "retire.valid after reset");
    check_bit(halted, 1'b0, "halted after reset");
  endtask

  task automatic test_addi_run();
    rv_core_pkg::reg_id_t rd;
    rv_core_pkg::reg_id_t rs1;
    logic [11:0]          imm;
    for (int n = 0; n < N_ADDI; n++) begin
      rd = rv_core_pkg::reg_id_t'(take_bits(5));
      rs1 = rv_core_pkg::reg_id_t'(take_bits(5));
      imm = 12'(take_bits(12));
      issue(enc_addi(rd, rs1, imm));
    end
  endtask

  // each instruction reads what the previous one wrote
  task automatic test_dependent_chain();
    logic [11:0] imm;
    for (int n = 0; n < N_CHAIN; n++) begin
      imm = 12'(take_bits(12));
      issue(enc_addi(5'd5, 5'd5, imm));
      issue(enc_add(5'd6, 5'd6, 5'd5));
    end
  endtask

  task automatic test_auipc();
    rv_core_pkg::reg_id_t rd;
    logic [19:0]          imm;
    // most negative and minus one
    issue(enc_auipc(5'd10, 20'hfffff));
    issue(enc_auipc(5'd11, 20'h80000));
    for (int n = 0; n < N_AUIPC - 2; n++) begin
      rd = rv_core_pkg::reg_id_t'(take_bits(5));
      imm = 20'(take_bits(20));
      issue(enc_auipc(rd, imm));
    end
    issue(enc_add(5'd12, 5'd10, 5'd11));
  endtask

  task automatic test_x0_and_illegal();
    logic [24:0] bits;
    issue(enc_addi(5'd0, 5'd5, 12'h7ff));
    issue(enc_add(5'd7, 5'd0, 5'd0));
    // load opcode, outside the subset
    bits = 25'(take_bits(25));
    issue({bits, 7'b0000011});
    // its rd must still hold the old value
    issue(enc_addi(5'd13, bits[4:0], 12'h000));
    // sub looks like add except funct7
    issue({7'b0100000, 5'd6, 5'd5, 3'b000, 5'd5, 7'b0110011});
    issue(enc_add(5'd8, 5'd5, 5'd6));
  endtask

  task automatic test_ebreak();
    rv_core_pkg::word_t ebreak_pc;
    ebreak_pc = model_pc;
    issue(EBREAK);
    for (int n = 0; n < N_POST; n++) begin
      issue(enc_addi(5'd9, 5'd9, 12'(take_bits(12))));
    end
    check_word(current_pc, ebreak_pc + 64'd4, "current_pc parked after ebreak");
    check_bit(halted, 1'b1, "halted after ebreak");
  endtask

  initial begin
    reset = 1'b1;
    inst = NOP;
    model_pc = `RESET_PC;
    model_halted = 1'b0;
    exp_halted = 1'b0;
    for (int k = 0; k < 32; k++) begin
      shadow[k] = '0;
    end
    test_reset();
    test_addi_run();
    test_dependent_chain();
    test_auipc();
    test_x0_and_illegal();
    test_ebreak();
    // bound assertion failures count as errors too
    errors += dut0.u_rv_core_sva.assert_failures;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- verification/rv_core_sva.sv
module rv_core_sva (
  input logic                 clk,
  input logic                 reset,
  input rv_core_pkg::inst_t   inst,
  input rv_core_pkg::word_t   current_pc,
  input rv_core_pkg::word_t   next_pc,
  input rv_core_pkg::retire_t retire,
  input logic                 halted
);
  timeunit 1ns;
  timeprecision 100ps;

  // the single ebreak encoding
  localparam rv_core_pkg::inst_t EBREAK_INST = 32'h0010_0073;

  // failures seen by the properties below
  int assert_failures = 0;

  // reset clears the retire register at the next edge
  assert property (@(posedge clk) reset |=> !retire.valid)
    else begin
      $error("retire valid while reset active");
      assert_failures++;
    end

  // sequential fetch until decode has captured an ebreak
  // decode freezes one cycle before execute raises halted
  assert property (@(posedge clk) disable iff (reset)
    (!halted && !$past(inst == EBREAK_INST)) |-> (next_pc == current_pc + 64'd4))
    else begin
      $error("next_pc did not step by four");
      assert_failures++;
    end

  // x0 never counts as written
  assert property (@(posedge clk) disable iff (reset)
    retire.wrote |-> (retire.rd != '0))
    else begin
      $error("retire reports a write to x0");
      assert_failures++;
    end

endmodule

bind rv_core rv_core_sva u_rv_core_sva (
  .clk        (clk),
  .reset      (reset),
  .inst       (inst),
  .current_pc (current_pc),
  .next_pc    (next_pc),
  .retire     (retire),
  .halted     (halted)
);

//--- src/rv_core.sv
module rv_core (
  input  logic                 clk,
  input  logic                 reset,
  input  rv_core_pkg::inst_t   inst,
  output rv_core_pkg::word_t   current_pc,
  output rv_core_pkg::word_t   next_pc,
  output rv_core_pkg::retire_t retire,
  output logic                 halted
);

  // decode to fetch freeze
  logic                  halt_req;
  // decode to execute pipeline register
  rv_core_pkg::decoded_t dec;

  // inst belongs to current_pc in the same cycle
  fetch_pc u_fetch_pc (
    .clk      (clk),
    .reset    (reset),
    .halt_req (halt_req),
    .pc       (current_pc),
    .next_pc  (next_pc)
  );

  // first stage, registers the decoded fields
  decode_stage u_decode_stage (
    .clk      (clk),
    .reset    (reset),
    .inst     (inst),
    .pc       (current_pc),
    .halt_req (halt_req),
    .dec      (dec)
  );

  // second stage
  // regfile read, alu and write back
  execute_stage u_execute_stage (
    .clk    (clk),
    .reset  (reset),
    .dec    (dec),
    .retire (retire),
    .halted (halted)
  );

endmodule

//--- src/execute_stage.sv
module execute_stage (
  input  logic                  clk,
  input  logic                  reset,
  input  rv_core_pkg::decoded_t dec,
  output rv_core_pkg::retire_t  retire,
  output logic                  halted
);

  rv_core_pkg::word_t   rdata_1;
  rv_core_pkg::word_t   rdata_2;
  rv_core_pkg::word_t   op_a;
  rv_core_pkg::word_t   op_b;
  rv_core_pkg::word_t   result;
  logic                 wen;
  rv_core_pkg::retire_t retire_d;

  // read in execute, write at end of the same cycle
  // so the next instruction sees the value without forwarding
  register_file u_register_file (
    .clk     (clk),
    .reset   (reset),
    .wen     (wen),
    .rd      (dec.rd),
    .wdata   (result),
    .rs1     (dec.rs1),
    .rs2     (dec.rs2),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2)
  );

  // operand muxes
  assign op_a = dec.use_pc ? dec.pc : rdata_1;
  assign op_b = dec.use_imm ? dec.imm : rdata_2;

  // alu
  always_comb begin
    case (dec.alu_op)
      rv_core_pkg::ALU_ADD: result = op_a + op_b;
      default: result = op_b;
    endcase
  end

  // x0 destination retires as no write
  assign wen = dec.valid && dec.writes_rd && (dec.rd != '0);

  // retire record
  always_comb begin
    retire_d.valid = dec.valid;
    retire_d.pc = dec.pc;
    retire_d.rd = dec.rd;
    retire_d.data = result;
    retire_d.wrote = wen;
    retire_d.illegal = dec.valid && dec.is_illegal;
    retire_d.ebreak = dec.valid && dec.is_ebreak;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      retire <= '0;
      halted <= 1'b0;
    end else begin
      retire <= retire_d;
      // sticky until reset
      if (dec.valid && dec.is_ebreak) begin
        halted <= 1'b1;
      end
    end
  end

endmodule

//--- src/register_file.sv
module register_file (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 wen,
  input  rv_core_pkg::reg_id_t rd,
  input  rv_core_pkg::word_t   wdata,
  input  rv_core_pkg::reg_id_t rs1,
  input  rv_core_pkg::reg_id_t rs2,
  output rv_core_pkg::word_t   rdata_1,
  output rv_core_pkg::word_t   rdata_2
);

  // x1..x31 only, x0 has no storage
  rv_core_pkg::word_t regs [1:31];

  // write port, index zero falls through
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  // read ports, x0 always reads zero
  assign rdata_1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata_2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- src/decode_stage.sv
`include "rv_core_settings.svh"

module decode_stage (
  input  logic                  clk,
  input  logic                  reset,
  input  rv_core_pkg::inst_t    inst,
  input  rv_core_pkg::word_t    pc,
  output logic                  halt_req,
  output rv_core_pkg::decoded_t dec
);

  // major opcodes
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  // funct fields for the add flavours
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [6:0] F7_ADD = 7'b0000000;

  // ebreak has exactly one legal encoding
  localparam rv_core_pkg::inst_t EBREAK_INST = 32'h0010_0073;

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic                  is_addi;
  logic                  is_add;
  logic                  is_auipc;
  logic                  is_ebreak;
  rv_core_pkg::word_t    imm_i;
  rv_core_pkg::word_t    imm_u;
  rv_core_pkg::decoded_t dec_d;
  logic                  halted;

  // field slices
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // instruction match
  assign is_addi   = (opcode == OPC_OP_IMM) && (funct3 == F3_ADD);
  assign is_add    = (opcode == OPC_OP) && (funct3 == F3_ADD) && (funct7 == F7_ADD);
  assign is_auipc  = (opcode == OPC_AUIPC);
  assign is_ebreak = (inst == EBREAK_INST);

  // i-type immediate, sign extended from bit 31
  assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
  // u-type: upper 20 bits, low 12 zero, then sign extended to xlen
  assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};

  // combinational decode
  always_comb begin
    dec_d = '0;
    // nothing after ebreak is allowed to become valid
    dec_d.valid = !halted;
    dec_d.pc = pc;
    dec_d.rd = inst[11:7];
    dec_d.rs1 = inst[19:15];
    dec_d.rs2 = inst[24:20];
    // default is a harmless pass of zero
    dec_d.alu_op = rv_core_pkg::ALU_PASS;
    dec_d.use_imm = 1'b1;
    dec_d.imm = '0;
    if (is_addi) begin
      dec_d.imm = imm_i;
      dec_d.alu_op = rv_core_pkg::ALU_ADD;
      dec_d.writes_rd = 1'b1;
    end else if (is_add) begin
      // register register form
      dec_d.use_imm = 1'b0;
      dec_d.alu_op = rv_core_pkg::ALU_ADD;
      dec_d.writes_rd = 1'b1;
    end else if (is_auipc) begin
      // pc relative, operand one is own pc
      dec_d.use_pc = 1'b1;
      dec_d.imm = imm_u;
      dec_d.alu_op = rv_core_pkg::ALU_ADD;
      dec_d.writes_rd = 1'b1;
    end else if (is_ebreak) begin
      dec_d.is_ebreak = 1'b1;
    end else begin
      // anything else retires without a write
      dec_d.is_illegal = 1'b1;
    end
  end

  // pipeline register and halt flag
  always_ff @(posedge clk) begin
    if (reset) begin
      dec <= '0;
      halted <= 1'b0;
    end else begin
      dec <= dec_d;
      if (is_ebreak && !halted) begin
        halted <= 1'b1;
      end
    end
  end

  // fetch freezes from the edge after ebreak capture
  // so pc parks at ebreak address plus four
  assign halt_req = halted;

endmodule

//--- src/fetch_pc.sv
`include "rv_core_settings.svh"

module fetch_pc (
  input  logic               clk,
  input  logic               reset,
  input  logic               halt_req,
  output rv_core_pkg::word_t pc,
  output rv_core_pkg::word_t next_pc
);

  // sequential fetch only, no branches
  // halt freezes the counter where it is
  always_comb begin
    if (halt_req) begin
      next_pc = pc;
    end else begin
      next_pc = pc + rv_core_pkg::word_t'(4);
    end
  end

  // pc register
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

//--- src/rv_core_pkg.sv
`include "rv_core_settings.svh"

package rv_core_pkg;

  // data, immediates and program counter
  typedef logic [`XLEN-1:0] word_t;

  // architectural register index
  typedef logic [`REG_ID_WIDTH-1:0] reg_id_t;

  // raw fetched instruction
  typedef logic [`INST_WIDTH-1:0] inst_t;

  // alu function select
  // pass returns operand two unchanged
  typedef enum logic [0:0] {
    ALU_ADD,
    ALU_PASS
  } alu_op_e;

  // decode to execute pipeline register
  typedef struct packed {
    logic    valid;
    word_t   pc;
    reg_id_t rd;
    reg_id_t rs1;
    reg_id_t rs2;
    word_t   imm;
    logic    use_imm;
    logic    use_pc;
    alu_op_e alu_op;
    logic    writes_rd;
    logic    is_ebreak;
    logic    is_illegal;
  } decoded_t;

  // one record per retired instruction
  typedef struct packed {
    logic    valid;
    word_t   pc;
    reg_id_t rd;
    word_t   data;
    logic    wrote;
    logic    illegal;
    logic    ebreak;
  } retire_t;

endpackage

//--- src/rv_core_settings.svh
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// integer register and datapath width
`define XLEN 64

// five bits address x0..x31
`define REG_ID_WIDTH 5

// base ISA only, no compressed encodings
`define INST_WIDTH 32

// first fetch address after reset
`define RESET_PC 64'h8000_0000

`endif
